/* logic/valu_pkg.sv */
/*
  Shared types of the SIMD vector ALU. One lane works on 64-bit words.
  Element widths from 8 to 64 bits; vector length at most 1023 elements.
*/
`default_nettype none

package valu_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int unsigned ElenBits = 64;
  localparam int unsigned StrbBits = ElenBits / 8;
  // One done bit per instruction id
  localparam int unsigned NrVInsn  = 8;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [ElenBits-1:0]        elen_t;
  typedef logic [StrbBits-1:0]        strb_t;
  // Vector length in elements
  typedef logic [9:0]                 vl_t;
  typedef logic [4:0]                 vreg_t;
  // Word address inside the register file
  typedef logic [9:0]                 vaddr_t;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // Elements per word are 8 >> encoding
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } sew_e;

  typedef enum logic [3:0] {
    VADD, VSUB, VAND, VOR, VXOR,
    VMINU, VMIN, VMAXU, VMAX,
    VSLL, VSRL, VSRA
  } alu_op_e;

  //////////////////////////////
  // Payloads
  //////////////////////////////

  typedef struct packed {
    vid_t    id;
    alu_op_e op;
    sew_e    vsew;
    vreg_t   vd;
    vl_t     vl;
    logic    vm;          // Set means unmasked
    logic    use_scalar;  // Scalar replaces vs1
    elen_t   scalar_op;
  } valu_insn_t;

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } vrf_wr_t;

  // Number of elements packed in one 64-bit word
  function automatic logic [3:0] elems_per_word(sew_e sew);
    return 4'd8 >> sew;
  endfunction

endpackage

`default_nettype wire

/* logic/valu_insn_queue.sv */
/*
  Instruction queue with accept, issue and commit phases.
  One word issues per cycle; done pulses follow the commit order of the queue.
*/
`timescale 1ns/1ps
`default_nettype none

module valu_insn_queue #(
  parameter int unsigned InsnQueueDepth = 4
) (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  input  wire valu_pkg::valu_insn_t          insn_i,
  input  wire logic                          insn_valid_i,
  output logic                               insn_ready_o,
  input  wire logic [1:0]                    operand_valid_i,
  output logic [1:0]                         operand_ready_o,
  input  wire logic                          mask_valid_i,
  output logic                               mask_ready_o,
  input  wire logic                          rq_full_i,
  input  wire logic                          word_sent_i,
  output valu_pkg::valu_insn_t               issue_insn_o,
  output valu_pkg::vl_t                      issue_remaining_o,
  output logic                               issue_fire_o,
  output logic [valu_pkg::NrVInsn-1:0]       insn_done_o
);

  localparam int unsigned PntW = (InsnQueueDepth > 1) ? $clog2(InsnQueueDepth) : 1;
  localparam int unsigned CntW = $clog2(InsnQueueDepth + 1);

  typedef logic [PntW-1:0] pnt_t;
  typedef logic [CntW-1:0] cnt_t;

  // Instruction store, written on accept only
  valu_pkg::valu_insn_t mem_q [InsnQueueDepth];

  pnt_t accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Instructions waiting to issue, and waiting to commit
  cnt_t issue_cnt_q, commit_cnt_q;
  // Element counters, taken from vl until the first word moves
  valu_pkg::vl_t issue_rem_q, commit_rem_q;
  logic issue_started_q, commit_started_q;

  logic full, accept, issue_valid, issue_last, issue_done;
  valu_pkg::vl_t issue_epw, commit_epw, commit_rem;
  valu_pkg::valu_insn_t commit_insn;
  logic commit_done;

  function automatic pnt_t next_pnt(pnt_t p);
    return (p == pnt_t'(InsnQueueDepth - 1)) ? '0 : p + 1'b1;
  endfunction

  //////////////////////////////
  // Accept
  //////////////////////////////

  // Commit count covers every slot still in use
  assign full         = (commit_cnt_q == cnt_t'(InsnQueueDepth));
  assign insn_ready_o = !full;
  assign accept       = insn_valid_i && !full;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[accept_pnt_q] <= insn_i;
    end
  end

  //////////////////////////////
  // Issue
  //////////////////////////////

  assign issue_valid       = (issue_cnt_q != '0);
  assign issue_insn_o      = mem_q[issue_pnt_q];
  assign issue_remaining_o = issue_started_q ? issue_rem_q : issue_insn_o.vl;
  assign issue_epw = valu_pkg::vl_t'(valu_pkg::elems_per_word(issue_insn_o.vsew));

  // All needed operands present and room in the result queue
  assign issue_fire_o = issue_valid && operand_valid_i[1] && !rq_full_i &&
                        (issue_insn_o.use_scalar || operand_valid_i[0]) &&
                        (issue_insn_o.vm || mask_valid_i);

  // vs2 always consumed, vs1 only without scalar
  assign operand_ready_o = {issue_fire_o, issue_fire_o && !issue_insn_o.use_scalar};
  assign mask_ready_o    = issue_fire_o && !issue_insn_o.vm;

  // Last word once the remaining elements fit in one word
  assign issue_last = (issue_remaining_o <= issue_epw);
  assign issue_done = issue_fire_o && issue_last;

  //////////////////////////////
  // Commit
  //////////////////////////////

  assign commit_insn = mem_q[commit_pnt_q];
  assign commit_rem  = commit_started_q ? commit_rem_q : commit_insn.vl;
  assign commit_epw  = valu_pkg::vl_t'(valu_pkg::elems_per_word(commit_insn.vsew));
  assign commit_done = word_sent_i && (commit_rem <= commit_epw);

  // Done pulse rides with the last word on the write port
  always_comb begin
    insn_done_o = '0;
    if (commit_done) begin
      insn_done_o[commit_insn.id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q     <= '0;
      issue_pnt_q      <= '0;
      commit_pnt_q     <= '0;
      issue_cnt_q      <= '0;
      commit_cnt_q     <= '0;
      issue_rem_q      <= '0;
      commit_rem_q     <= '0;
      issue_started_q  <= 1'b0;
      commit_started_q <= 1'b0;
    end else begin
      if (accept) begin
        accept_pnt_q <= next_pnt(accept_pnt_q);
      end
      if (issue_fire_o) begin
        if (issue_last) begin
          issue_pnt_q     <= next_pnt(issue_pnt_q);
          issue_started_q <= 1'b0;
        end else begin
          issue_rem_q     <= issue_remaining_o - issue_epw;
          issue_started_q <= 1'b1;
        end
      end
      if (word_sent_i) begin
        if (commit_done) begin
          commit_pnt_q     <= next_pnt(commit_pnt_q);
          commit_started_q <= 1'b0;
        end else begin
          commit_rem_q     <= commit_rem - commit_epw;
          commit_started_q <= 1'b1;
        end
      end
      issue_cnt_q  <= issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_done);
      commit_cnt_q <= commit_cnt_q + cnt_t'(accept) - cnt_t'(commit_done);
    end
  end

  // Accept slot is never one still waiting to commit
  a_no_accept_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept && commit_cnt_q != '0 |-> accept_pnt_q != commit_pnt_q)
    else $error("instruction accepted over a slot in use");

  // Words leave the result queue only for queued instructions
  a_sent_has_commit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    word_sent_i |-> commit_cnt_q != '0)
    else $error("word sent without a commit instruction");

endmodule

`default_nettype wire

/* logic/valu_simd_alu.sv */
/*
  Combinational SIMD integer datapath on one 64-bit word.
  VSUB and the shifts take vs2 as the value and vs1 as the subtrahend or amount.
*/
`timescale 1ns/1ps
`default_nettype none

module valu_simd_alu (
  input  wire valu_pkg::valu_insn_t insn_i,
  input  wire valu_pkg::elen_t      operand_a_i,
  input  wire valu_pkg::elen_t      operand_b_i,
  output valu_pkg::elen_t           result_o
);

  valu_pkg::elen_t scalar_rep;
  valu_pkg::elen_t op_a;

  // One element, zero-extended to 64 bits, of width w
  function automatic valu_pkg::elen_t elem_op(valu_pkg::alu_op_e op, valu_pkg::elen_t a,
                                              valu_pkg::elen_t b, int unsigned w);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [5:0]         sh;
    // Signed views for min, max and arithmetic shift
    sa = $signed(a << (64 - w)) >>> (64 - w);
    sb = $signed(b << (64 - w)) >>> (64 - w);
    // Shift amount modulo element width
    sh = a[5:0] & 6'(w - 1);
    case (op)
      valu_pkg::VADD:  elem_op = b + a;
      valu_pkg::VSUB:  elem_op = b - a;
      valu_pkg::VAND:  elem_op = b & a;
      valu_pkg::VOR:   elem_op = b | a;
      valu_pkg::VXOR:  elem_op = b ^ a;
      valu_pkg::VMINU: elem_op = (a < b) ? a : b;
      valu_pkg::VMIN:  elem_op = (sa < sb) ? a : b;
      valu_pkg::VMAXU: elem_op = (a > b) ? a : b;
      valu_pkg::VMAX:  elem_op = (sa > sb) ? a : b;
      valu_pkg::VSLL:  elem_op = b << sh;
      valu_pkg::VSRL:  elem_op = b >> sh;
      valu_pkg::VSRA:  elem_op = sb >>> sh;
      default:         elem_op = '0;
    endcase
  endfunction

  //////////////////////////////
  // Operand select
  //////////////////////////////

  // Scalar copied into every element slot
  always_comb begin
    case (insn_i.vsew)
      valu_pkg::EW8:  scalar_rep = {8{insn_i.scalar_op[7:0]}};
      valu_pkg::EW16: scalar_rep = {4{insn_i.scalar_op[15:0]}};
      valu_pkg::EW32: scalar_rep = {2{insn_i.scalar_op[31:0]}};
      default:        scalar_rep = insn_i.scalar_op;
    endcase
  end

  assign op_a = insn_i.use_scalar ? scalar_rep : operand_a_i;

  //////////////////////////////
  // Per-element lanes
  //////////////////////////////

  always_comb begin
    valu_pkg::elen_t elem;
    result_o = '0;
    case (insn_i.vsew)
      valu_pkg::EW8: begin
        for (int i = 0; i < 8; i++) begin
          elem = elem_op(insn_i.op, 64'(op_a[8*i +: 8]), 64'(operand_b_i[8*i +: 8]), 8);
          result_o[8*i +: 8] = elem[7:0];
        end
      end
      valu_pkg::EW16: begin
        for (int i = 0; i < 4; i++) begin
          elem = elem_op(insn_i.op, 64'(op_a[16*i +: 16]), 64'(operand_b_i[16*i +: 16]), 16);
          result_o[16*i +: 16] = elem[15:0];
        end
      end
      valu_pkg::EW32: begin
        for (int i = 0; i < 2; i++) begin
          elem = elem_op(insn_i.op, 64'(op_a[32*i +: 32]), 64'(operand_b_i[32*i +: 32]), 32);
          result_o[32*i +: 32] = elem[31:0];
        end
      end
      default: begin
        result_o = elem_op(insn_i.op, op_a, operand_b_i, 64);
      end
    endcase
  end

endmodule

`default_nettype wire

/* logic/valu_write_ctrl.sv */
/*
  Address and byte enables of the word being issued.
  Registers are WordsPerReg words long; mask_i is one bit per byte.
*/
`timescale 1ns/1ps
`default_nettype none

module valu_write_ctrl #(
  parameter int unsigned WordsPerReg = 16
) (
  input  wire valu_pkg::valu_insn_t insn_i,
  input  wire valu_pkg::vl_t        remaining_i,
  input  wire valu_pkg::strb_t      mask_i,
  output valu_pkg::vaddr_t          addr_o,
  output valu_pkg::strb_t           be_o
);

  logic [3:0]    epw;
  valu_pkg::vl_t done_elems;
  valu_pkg::vl_t word_idx;
  logic [3:0]    n_elems;
  logic [3:0]    n_bytes;
  logic [8:0]    elem_be;

  assign epw = valu_pkg::elems_per_word(insn_i.vsew);

  //////////////////////////////
  // Address
  //////////////////////////////

  // Elements already issued, turned into a word index
  assign done_elems = insn_i.vl - remaining_i;
  assign word_idx   = done_elems >> (2'd3 - insn_i.vsew);
  assign addr_o     = valu_pkg::vaddr_t'(insn_i.vd * WordsPerReg + word_idx);

  //////////////////////////////
  // Byte enables
  //////////////////////////////

  // Tail word holds fewer elements
  assign n_elems = (remaining_i < valu_pkg::vl_t'(epw)) ? remaining_i[3:0] : epw;
  assign n_bytes = n_elems << insn_i.vsew;
  assign elem_be = (9'd1 << n_bytes) - 9'd1;

  // Masked instructions also drop inactive bytes
  assign be_o = elem_be[7:0] & (insn_i.vm ? {valu_pkg::StrbBits{1'b1}} : mask_i);

endmodule

`default_nettype wire

/* logic/valu_result_queue.sv */
/*
  Result FIFO towards the register file with credit flow control.
  A word leaves only while a credit is held; credits start at VrfCredits.
*/
`timescale 1ns/1ps
`default_nettype none

module valu_result_queue #(
  parameter int unsigned ResultQueueDepth = 2,
  parameter int unsigned VrfCredits       = 2
) (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             push_i,
  input  wire valu_pkg::elen_t  data_i,
  input  wire valu_pkg::vid_t   id_i,
  input  wire valu_pkg::vaddr_t addr_i,
  input  wire valu_pkg::strb_t  be_i,
  output logic                  full_o,
  output valu_pkg::vrf_wr_t     vrf_wr_o,
  output logic                  vrf_valid_o,
  input  wire logic             vrf_credit_i,
  output logic                  word_sent_o
);

  localparam int unsigned PntW = (ResultQueueDepth > 1) ? $clog2(ResultQueueDepth) : 1;
  localparam int unsigned CntW = $clog2(ResultQueueDepth + 1);
  localparam int unsigned CrdW = $clog2(VrfCredits + 1);

  typedef logic [PntW-1:0] pnt_t;
  typedef logic [CntW-1:0] cnt_t;
  typedef logic [CrdW-1:0] crd_t;

  valu_pkg::vrf_wr_t fifo_q [ResultQueueDepth];
  valu_pkg::vrf_wr_t push_entry;

  pnt_t wr_pnt_q, rd_pnt_q;
  cnt_t cnt_q;
  crd_t credit_q;
  logic pop;

  function automatic pnt_t next_pnt(pnt_t p);
    return (p == pnt_t'(ResultQueueDepth - 1)) ? '0 : p + 1'b1;
  endfunction

  // ALU data joined with id, address and enables
  assign push_entry = '{id: id_i, addr: addr_i, wdata: data_i, be: be_i};

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      fifo_q[wr_pnt_q] <= push_entry;
    end
  end

  // Head goes out whenever a credit is available
  assign full_o      = (cnt_q == cnt_t'(ResultQueueDepth));
  assign pop         = (cnt_q != '0) && (credit_q != '0);
  assign vrf_valid_o = pop;
  assign vrf_wr_o    = fifo_q[rd_pnt_q];
  assign word_sent_o = vrf_valid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
      credit_q <= crd_t'(VrfCredits);
    end else begin
      if (push_i) begin
        wr_pnt_q <= next_pnt(wr_pnt_q);
      end
      if (pop) begin
        rd_pnt_q <= next_pnt(rd_pnt_q);
      end
      cnt_q    <= cnt_q + cnt_t'(push_i) - cnt_t'(pop);
      // One credit spent per word, one back per return
      credit_q <= credit_q - crd_t'(pop) + crd_t'(vrf_credit_i);
    end
  end

  // Issue side holds off while the FIFO is full
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o)
    else $error("push into a full result queue");

  // Register file never returns more credits than it granted
  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= crd_t'(VrfCredits))
    else $error("credit count above VrfCredits");

endmodule

`default_nettype wire

/* logic/valu_top.sv */
/*
  Single-lane SIMD vector ALU with queued instructions.
  operand_i[1] is vs2, operand_i[0] is vs1; writes use credit flow control.
*/
`timescale 1ns/1ps
`default_nettype none

module valu_top #(
  parameter int unsigned InsnQueueDepth   = 4,
  parameter int unsigned ResultQueueDepth = 2,
  parameter int unsigned VrfCredits       = 2,
  parameter int unsigned WordsPerReg      = 16
) (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  input  wire valu_pkg::valu_insn_t        insn_i,
  input  wire logic                        insn_valid_i,
  output logic                             insn_ready_o,
  input  wire valu_pkg::elen_t [1:0]       operand_i,
  input  wire logic [1:0]                  operand_valid_i,
  output logic [1:0]                       operand_ready_o,
  input  wire valu_pkg::strb_t             mask_i,
  input  wire logic                        mask_valid_i,
  output logic                             mask_ready_o,
  output valu_pkg::vrf_wr_t                vrf_wr_o,
  output logic                             vrf_valid_o,
  input  wire logic                        vrf_credit_i,
  output logic [valu_pkg::NrVInsn-1:0]     insn_done_o
);

  valu_pkg::valu_insn_t issue_insn;
  valu_pkg::vl_t        issue_remaining;
  logic                 issue_fire;
  logic                 rq_full;
  logic                 word_sent;
  valu_pkg::elen_t      alu_result;
  valu_pkg::vaddr_t     wr_addr;
  valu_pkg::strb_t      wr_be;

  valu_insn_queue #(
    .InsnQueueDepth(InsnQueueDepth)
  ) u_insn_queue (
    .clk_i, .rst_ni, .insn_i, .insn_valid_i, .insn_ready_o,
    .operand_valid_i, .operand_ready_o, .mask_valid_i, .mask_ready_o,
    .rq_full_i         (rq_full),
    .word_sent_i       (word_sent),
    .issue_insn_o      (issue_insn),
    .issue_remaining_o (issue_remaining),
    .issue_fire_o      (issue_fire),
    .insn_done_o
  );

  // Datapath and write control both look at the issuing instruction
  valu_simd_alu u_simd_alu (
    .insn_i      (issue_insn),
    .operand_a_i (operand_i[0]),
    .operand_b_i (operand_i[1]),
    .result_o    (alu_result)
  );

  valu_write_ctrl #(
    .WordsPerReg(WordsPerReg)
  ) u_write_ctrl (
    .insn_i      (issue_insn),
    .remaining_i (issue_remaining),
    .mask_i      (mask_i),
    .addr_o      (wr_addr),
    .be_o        (wr_be)
  );

  valu_result_queue #(
    .ResultQueueDepth (ResultQueueDepth),
    .VrfCredits       (VrfCredits)
  ) u_result_queue (
    .clk_i, .rst_ni,
    .push_i       (issue_fire),
    .data_i       (alu_result),
    .id_i         (issue_insn.id),
    .addr_i       (wr_addr),
    .be_i         (wr_be),
    .full_o       (rq_full),
    .vrf_wr_o, .vrf_valid_o, .vrf_credit_i,
    .word_sent_o  (word_sent)
  );

endmodule

`default_nettype wire

/* verification/valu_tb.sv */
/*
  Directed testbench for the SIMD vector ALU with default parameters.
  Expected words come from a reference model and are checked in order on the write port.
*/
`timescale 1ns/1ps
`default_nettype none

module valu_tb;

  localparam int unsigned VrfCredits  = 2;
  localparam int unsigned WordsPerReg = 16;
  // Words over all tests and cycles allowed per word
  localparam int TotalWords  = 53;
  localparam int CycleMargin = 20;
  localparam int MaxCycles   = 300 + TotalWords * CycleMargin;
  // Register file hands a credit back this many cycles after its word
  localparam int CreditDelay = 3;

  typedef struct packed {
    valu_pkg::vrf_wr_t wr;
    logic              last;
  } exp_word_t;

  // Operands of one issued word
  typedef struct packed {
    valu_pkg::elen_t vs2;
    valu_pkg::elen_t vs1;
    valu_pkg::strb_t mask;
    logic            need_vs1;
    logic            need_mask;
  } opnd_t;

  logic                         clk_i;
  logic                         rst_ni;
  valu_pkg::valu_insn_t         insn_i;
  logic                         insn_valid_i;
  logic                         insn_ready_o;
  valu_pkg::elen_t [1:0]        operand_i;
  logic [1:0]                   operand_valid_i;
  logic [1:0]                   operand_ready_o;
  valu_pkg::strb_t              mask_i;
  logic                         mask_valid_i;
  logic                         mask_ready_o;
  valu_pkg::vrf_wr_t            vrf_wr_o;
  logic                         vrf_valid_o;
  logic                         vrf_credit_i;
  logic [valu_pkg::NrVInsn-1:0] insn_done_o;

  // Stimulus and expectation queues
  valu_pkg::valu_insn_t insn_q[$];
  opnd_t                opnd_q[$];
  exp_word_t            exp_q[$];
  int                   credit_due_q[$];
  int                   done_order_q[$];
  int                   done_cnt[valu_pkg::NrVInsn];

  integer                       seed;
  int                           cycle;
  int                           err_cnt;
  int                           sent_cnt;
  logic                         withhold;
  exp_word_t                    exp_head;
  logic [63:0]                  byte_mask;
  logic [valu_pkg::NrVInsn-1:0] exp_done;

  always #4 clk_i = ~clk_i;

  valu_top dut0 (
    .clk_i, .rst_ni,
    .insn_i, .insn_valid_i, .insn_ready_o,
    .operand_i, .operand_valid_i, .operand_ready_o,
    .mask_i, .mask_valid_i, .mask_ready_o,
    .vrf_wr_o, .vrf_valid_o, .vrf_credit_i,
    .insn_done_o
  );

  //////////////////////////////
  // Checks and reference model
  //////////////////////////////

  task automatic check_eq(input logic [127:0] got, input logic [127:0] exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t ns: %s got %0h expected %0h", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // One element of width w; a is the vs1 side, b the vs2 side
  function automatic logic [63:0] elem_result(valu_pkg::alu_op_e op, logic [63:0] a,
                                              logic [63:0] b, int w);
    logic [63:0] m;
    longint      sa;
    longint      sb;
    int          sh;
    logic [63:0] r;
    m  = (w == 64) ? {64{1'b1}} : (64'd1 << w) - 64'd1;
    a  = a & m;
    b  = b & m;
    sa = a[w-1] ? longint'(a | ~m) : longint'(a);
    sb = b[w-1] ? longint'(b | ~m) : longint'(b);
    sh = int'(a % 64'(w));
    case (op)
      valu_pkg::VADD:  r = b + a;
      valu_pkg::VSUB:  r = b - a;
      valu_pkg::VAND:  r = b & a;
      valu_pkg::VOR:   r = b | a;
      valu_pkg::VXOR:  r = b ^ a;
      valu_pkg::VMINU: r = (a < b) ? a : b;
      valu_pkg::VMIN:  r = (sa < sb) ? a : b;
      valu_pkg::VMAXU: r = (a > b) ? a : b;
      valu_pkg::VMAX:  r = (sa > sb) ? a : b;
      valu_pkg::VSLL:  r = b << sh;
      valu_pkg::VSRL:  r = b >> sh;
      valu_pkg::VSRA:  r = 64'(sb >>> sh);
      default:         r = '0;
    endcase
    return r & m;
  endfunction

  // Whole word, scalar copied into every element when selected
  function automatic valu_pkg::elen_t word_result(valu_pkg::valu_insn_t insn,
                                                  valu_pkg::elen_t vs2, valu_pkg::elen_t vs1);
    int          w;
    logic [63:0] m;
    logic [63:0] opa;
    logic [63:0] r;
    w   = 8 << insn.vsew;
    m   = (w == 64) ? {64{1'b1}} : (64'd1 << w) - 64'd1;
    opa = insn.use_scalar ? '0 : vs1;
    r   = '0;
    for (int i = 0; i < 64 / w; i++) begin
      if (insn.use_scalar) begin
        opa = opa | ((insn.scalar_op & m) << (i * w));
      end
    end
    for (int i = 0; i < 64 / w; i++) begin
      r = r | (elem_result(insn.op, opa >> (i * w), vs2 >> (i * w), w) << (i * w));
    end
    return r;
  endfunction

  // Queue one instruction with its operands and expected words
  task automatic send_insn(input valu_pkg::vid_t id, input valu_pkg::alu_op_e op,
                           input valu_pkg::sew_e sew, input valu_pkg::vreg_t vd,
                           input valu_pkg::vl_t vl, input logic vm, input logic use_scalar);
    valu_pkg::valu_insn_t insn;
    opnd_t                opnd;
    exp_word_t            e;
    int                   epw;
    int                   rem;
    int                   n;
    int                   k;
    insn.id         = id;
    insn.op         = op;
    insn.vsew       = sew;
    insn.vd         = vd;
    insn.vl         = vl;
    insn.vm         = vm;
    insn.use_scalar = use_scalar;
    insn.scalar_op  = {$random(seed), $random(seed)};
    epw = 8 >> sew;
    rem = vl;
    k   = 0;
    while (rem > 0) begin
      opnd.vs2       = {$random(seed), $random(seed)};
      opnd.vs1       = {$random(seed), $random(seed)};
      opnd.mask      = 8'($random(seed));
      // vs1 is taken only without scalar, the mask only when masked
      opnd.need_vs1  = !use_scalar;
      opnd.need_mask = !vm;
      n          = (rem < epw) ? rem : epw;
      e.wr.id    = id;
      e.wr.addr  = valu_pkg::vaddr_t'(vd * WordsPerReg + k);
      e.wr.wdata = word_result(insn, opnd.vs2, opnd.vs1);
      // Bytes of the active elements, n elements of 2**sew bytes
      e.wr.be    = (n << sew == 8) ? 8'hFF : 8'((1 << (n << sew)) - 1);
      if (!vm) begin
        e.wr.be = e.wr.be & opnd.mask;
      end
      e.last = (rem <= epw);
      opnd_q.push_back(opnd);
      exp_q.push_back(e);
      rem = rem - n;
      k++;
    end
    insn_q.push_back(insn);
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0 || insn_q.size() != 0 || credit_due_q.size() != 0) begin
      @(negedge clk_i);
    end
    repeat (2) @(negedge clk_i);
  endtask

  //////////////////////////////
  // Drivers and monitor
  //////////////////////////////

  // Inputs change on the falling edge only
  always @(negedge clk_i) begin
    if (insn_q.size() != 0) begin
      insn_i       <= insn_q[0];
      insn_valid_i <= 1'b1;
    end else begin
      insn_valid_i <= 1'b0;
    end
    if (opnd_q.size() != 0) begin
      operand_i       <= {opnd_q[0].vs2, opnd_q[0].vs1};
      mask_i          <= opnd_q[0].mask;
      operand_valid_i <= 2'b11;
      mask_valid_i    <= 1'b1;
    end else begin
      operand_valid_i <= 2'b00;
      mask_valid_i    <= 1'b0;
    end
  end

  // Credit return and watchdog share the cycle count
  always @(negedge clk_i) begin
    if (!withhold && credit_due_q.size() != 0 && credit_due_q[0] <= cycle) begin
      vrf_credit_i <= 1'b1;
      void'(credit_due_q.pop_front());
    end else begin
      vrf_credit_i <= 1'b0;
    end
    cycle++;
    if (cycle > MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("ERRORS FOUND");
      $fatal(1, "Timeout");
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (insn_valid_i && insn_ready_o) begin
        void'(insn_q.pop_front());
      end
      // vs2 ready marks every issued word; vs1 and mask follow their use
      if (operand_ready_o[1]) begin
        check_eq(operand_ready_o[0], opnd_q[0].need_vs1, "vs1 ready");
        check_eq(mask_ready_o, opnd_q[0].need_mask, "mask ready");
        void'(opnd_q.pop_front());
      end else begin
        check_eq(operand_ready_o[0], 1'b0, "vs1 ready without an issued word");
        check_eq(mask_ready_o, 1'b0, "mask ready without an issued word");
      end
      if (vrf_valid_o) begin
        credit_due_q.push_back(cycle + CreditDelay);
        sent_cnt++;
        if (exp_q.size() == 0) begin
          $display("A word reached the register file with none expected at %0t ns", $time);
          $display("ERRORS FOUND");
          $fatal(1, "Unexpected write");
        end else begin
          exp_head = exp_q.pop_front();
          for (int b = 0; b < 8; b++) begin
            byte_mask[8*b +: 8] = {8{exp_head.wr.be[b]}};
          end
          exp_done = '0;
          if (exp_head.last) begin
            exp_done[exp_head.wr.id] = 1'b1;
          end
          check_eq(vrf_wr_o.id, exp_head.wr.id, "write id");
          check_eq(vrf_wr_o.addr, exp_head.wr.addr, "write address");
          check_eq(vrf_wr_o.be, exp_head.wr.be, "byte enables");
          // Data only on enabled bytes
          check_eq(vrf_wr_o.wdata & byte_mask, exp_head.wr.wdata & byte_mask, "write data");
          check_eq(insn_done_o, exp_done, "done pulse");
        end
      end else begin
        check_eq(insn_done_o, '0, "done pulse without a write");
      end
      for (int i = 0; i < valu_pkg::NrVInsn; i++) begin
        if (insn_done_o[i]) begin
          done_order_q.push_back(i);
          done_cnt[i]++;
        end
      end
    end
  end

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic idle_outputs(input string when);
    check_eq(vrf_valid_o, 1'b0, {"vrf_valid_o ", when});
    check_eq(insn_done_o, '0, {"insn_done_o ", when});
    check_eq(mask_ready_o, 1'b0, {"mask_ready_o ", when});
    check_eq(operand_ready_o, 2'b00, {"operand_ready_o ", when});
    check_eq(insn_ready_o, 1'b1, {"insn_ready_o ", when});
  endtask

  task automatic reset_values();
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    idle_outputs("in reset");
    rst_ni = 1'b1;
    @(negedge clk_i);
    idle_outputs("after reset");
  endtask

  task automatic vector_vector_ops();
    foreach (done_cnt[i]) done_cnt[i] = 0;
    // vl 5 at EW32 gives three words, the last half full
    send_insn(3'd0, valu_pkg::VADD, valu_pkg::EW32, 5'd3, 10'd5, 1'b1, 1'b0);
    send_insn(3'd1, valu_pkg::VSUB, valu_pkg::EW32, 5'd4, 10'd5, 1'b1, 1'b0);
    wait_idle();
    check_eq(done_cnt[0], 1, "done count of id 0");
    check_eq(done_cnt[1], 1, "done count of id 1");
  endtask

  task automatic scalar_ops();
    send_insn(3'd2, valu_pkg::VXOR, valu_pkg::EW8, 5'd5, 10'd16, 1'b1, 1'b1);
    send_insn(3'd3, valu_pkg::VMIN, valu_pkg::EW16, 5'd6, 10'd9, 1'b1, 1'b1);
    send_insn(3'd4, valu_pkg::VMAXU, valu_pkg::EW8, 5'd7, 10'd12, 1'b1, 1'b1);
    send_insn(3'd5, valu_pkg::VMIN, valu_pkg::EW8, 5'd8, 10'd8, 1'b1, 1'b1);
    // Shift amount from the scalar, modulo 64
    send_insn(3'd6, valu_pkg::VSLL, valu_pkg::EW64, 5'd9, 10'd3, 1'b1, 1'b1);
    send_insn(3'd7, valu_pkg::VSRA, valu_pkg::EW64, 5'd10, 10'd3, 1'b1, 1'b1);
    wait_idle();
  endtask

  task automatic masked_writes();
    send_insn(3'd0, valu_pkg::VAND, valu_pkg::EW16, 5'd11, 10'd7, 1'b0, 1'b0);
    send_insn(3'd1, valu_pkg::VADD, valu_pkg::EW8, 5'd12, 10'd13, 1'b0, 1'b1);
    wait_idle();
  endtask

  task automatic credit_backpressure();
    int sent_before;
    withhold    = 1'b1;
    sent_before = sent_cnt;
    send_insn(3'd0, valu_pkg::VADD, valu_pkg::EW64, 5'd13, 10'd4, 1'b1, 1'b0);
    send_insn(3'd1, valu_pkg::VSUB, valu_pkg::EW64, 5'd14, 10'd4, 1'b1, 1'b0);
    send_insn(3'd2, valu_pkg::VOR, valu_pkg::EW64, 5'd15, 10'd4, 1'b1, 1'b0);
    send_insn(3'd3, valu_pkg::VMINU, valu_pkg::EW64, 5'd16, 10'd4, 1'b1, 1'b0);
    send_insn(3'd4, valu_pkg::VMAX, valu_pkg::EW64, 5'd17, 10'd4, 1'b1, 1'b0);
    // Result queue fills, then the instruction queue
    while (insn_ready_o) begin
      @(negedge clk_i);
    end
    repeat (8) @(negedge clk_i);
    check_eq(sent_cnt - sent_before <= VrfCredits, 1'b1, "words sent without credits");
    check_eq(insn_ready_o, 1'b0, "insn_ready_o while stalled");
    withhold = 1'b0;
    wait_idle();
  endtask

  task automatic queued_insns();
    done_order_q.delete();
    send_insn(3'd4, valu_pkg::VADD, valu_pkg::EW8, 5'd20, 10'd20, 1'b1, 1'b0);
    send_insn(3'd5, valu_pkg::VSUB, valu_pkg::EW16, 5'd21, 10'd6, 1'b1, 1'b0);
    send_insn(3'd6, valu_pkg::VMAX, valu_pkg::EW32, 5'd22, 10'd3, 1'b1, 1'b0);
    send_insn(3'd7, valu_pkg::VSRL, valu_pkg::EW64, 5'd23, 10'd2, 1'b1, 1'b0);
    wait_idle();
    check_eq(done_order_q.size(), 4, "number of done pulses");
    for (int i = 0; i < done_order_q.size(); i++) begin
      check_eq(done_order_q[i], 4 + i, "done order");
    end
  endtask

  initial begin
    seed            = 32'hb895;
    cycle           = 0;
    err_cnt         = 0;
    sent_cnt        = 0;
    withhold        = 1'b0;
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    insn_i          = '0;
    insn_valid_i    = 1'b0;
    operand_i       = '0;
    operand_valid_i = 2'b00;
    mask_i          = '0;
    mask_valid_i    = 1'b0;
    vrf_credit_i    = 1'b0;
    foreach (done_cnt[i]) done_cnt[i] = 0;
    reset_values();
    vector_vector_ops();
    scalar_ops();
    masked_writes();
    credit_backpressure();
    queued_insns();
    wait_idle();
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
logic/valu_pkg.sv
logic/valu_insn_queue.sv
logic/valu_simd_alu.sv
logic/valu_write_ctrl.sv
logic/valu_result_queue.sv
logic/valu_top.sv
verification/valu_tb.sv
